// File: flash_lcmgr.f
+incdir+include
hdl/flash_lcmgr_flash_pkg.sv
hdl/flash_lcmgr_ctrl_pkg.sv
hdl/flash_lcmgr_seed_rd.sv
hdl/flash_lcmgr_rma_wipe.sv
hdl/flash_lcmgr_top.sv
tests/tb_clkgen.sv
tests/flash_model.sv
tests/flash_lcmgr_tb.sv

// File: Makefile
# Verilator build for the flash life-cycle manager

VERILATOR ?= verilator
TOP       ?= flash_lcmgr_tb
FILELIST  ?= flash_lcmgr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/flash_lcmgr_tb.sv
/*
 * Flash life-cycle manager testbench
 * - LFSR stimulus, flash model and reference copy of the flash
 * - seed read, provisioning, seed error, RMA wipe and compare fault tests
 * - watchdog
 */
`timescale 1ns/1ps
`include "flash_lcmgr_consts.svh"

module flash_lcmgr_tb;

  logic clk, rst_n, init, prov_en, rma_req, stall, inj_err, inj_flip, load_en;
  logic done, err, rvalid, wready, wvalid;
  logic seed_err, rma_ack, dis_access, init_busy, initialized, fatal_err;
  logic [`FLM_ADDR_W:0] load_idx;
  logic [31:0] lfsr;
  int n_start, n_erase, n_info_rd, wbeat, n_wr;
  int n_xfer = 0;
  int n_rand = 0;
  int erase_cnt [2 ** (`FLM_ADDR_W - `FLM_WORD_W)];

  flash_lcmgr_flash_pkg::bus_word_t   rdata, wdata, rand_word, load_data;
  flash_lcmgr_flash_pkg::flash_cmd_t  cmd;
  flash_lcmgr_ctrl_pkg::seeds_t       seeds;
  flash_lcmgr_ctrl_pkg::lcmgr_phase_e phase;
  flash_lcmgr_flash_pkg::bus_word_t   ref_mem [2 ** (`FLM_ADDR_W + 1)];

  tb_clkgen u_clkgen (.clk_o(clk));

  flash_lcmgr_top u_flash_lcmgr_top (
    .clk_i(clk), .rst_ni(rst_n), .init_i(init), .provision_en_i(prov_en),
    .rma_req_i(rma_req), .done_i(done), .err_i(err), .rvalid_i(rvalid), .rdata_i(rdata),
    .wready_i(wready), .rand_i(rand_word), .cmd_o(cmd), .wvalid_o(wvalid), .wdata_o(wdata),
    .seeds_o(seeds), .seed_err_o(seed_err), .rma_ack_o(rma_ack), .dis_access_o(dis_access),
    .init_busy_o(init_busy), .initialized_o(initialized), .fatal_err_o(fatal_err),
    .phase_o(phase)
  );

  flash_model u_flash (
    .clk_i(clk), .rst_ni(rst_n), .cmd_i(cmd), .wvalid_i(wvalid), .wdata_i(wdata),
    .stall_i(stall), .inj_err_i(inj_err), .inj_flip_i(inj_flip), .load_en_i(load_en),
    .load_idx_i(load_idx), .load_data_i(load_data), .done_o(done), .err_o(err),
    .rvalid_o(rvalid), .wready_o(wready), .rdata_o(rdata)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // 0 initialized, 1 rma ack, 2 fatal error
  task automatic wait_for(input int which, input string what);
    logic hit;
    for (int i = 0; i < 4000; i++) begin
      @(negedge clk);
      hit = (which == 0) ? initialized : (which == 1) ? rma_ack : fatal_err;
      if (hit) return;
    end
    $display("timed out waiting for %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "handshake timeout");
  endtask

  task automatic reset_dut(input logic err_inj, input logic flip_inj);
    @(negedge clk);
    rst_n     = 1'b0;
    init      = 1'b0;
    prov_en   = 1'b0;
    rma_req   = 1'b0;
    inj_err   = err_inj;
    inj_flip  = flip_inj;
    n_start   = 0;
    n_erase   = 0;
    n_info_rd = 0;
    n_wr      = 0;
    wbeat     = 0;
    foreach (erase_cnt[p]) begin
      erase_cnt[p] = 0;
    end
    repeat (5) @(negedge clk);
    check("control outputs in reset",
          32'({cmd.start, wvalid, rma_ack, init_busy, initialized, seed_err, fatal_err,
               dis_access}), 32'd0);
    rst_n = 1'b1;
    // fresh seed pages for every test
    for (int s = 0; s < `FLM_NUM_SEEDS; s++) begin
      for (int w = 0; w < `FLM_SEED_WORDS; w++) begin
        load_en   = 1'b1;
        load_idx  = {1'b1, 6'(s == 0 ? `FLM_SEED0_PAGE : `FLM_SEED1_PAGE), 4'(w)};
        load_data = take_bits(32);
        ref_mem[load_idx] = load_data;
        @(negedge clk);
      end
    end
    load_en = 1'b0;
  endtask

  task automatic check_wipe();
    logic [`FLM_ADDR_W:0] idx;
    for (int p = 0; p < `FLM_WIPE_NUM_PAGES; p++) begin
      check("erases of page", 32'(erase_cnt[`FLM_WIPE_START_PAGE + p]), 32'd1);
      for (int w = 0; w < `FLM_WORDS_PER_PAGE; w++) begin
        idx = {1'b0, 6'(`FLM_WIPE_START_PAGE + p), 4'(w)};
        check("wiped word", u_flash.mem[idx], ref_mem[idx]);
      end
    end
    check("erase count", 32'(n_erase), 32'(`FLM_WIPE_NUM_PAGES));
    check("program beats", 32'(n_wr), 32'(`FLM_WIPE_NUM_PAGES * `FLM_WORDS_PER_PAGE));
    check("dis_access", 32'(dis_access), 32'd1);
  endtask

  // command and program beat monitor
  always @(posedge clk) begin
    if (cmd.start) begin
      n_start++;
      // info reads belong to the seed phase, data commands to the rma phase
      if (cmd.part == flash_lcmgr_flash_pkg::FlashPartInfo) begin
        check("phase in seed read", 32'(phase), 32'(flash_lcmgr_ctrl_pkg::PhaseSeed));
        check("init_busy in seed read", 32'(init_busy), 32'd1);
      end else begin
        check("phase in wipe", 32'(phase), 32'(flash_lcmgr_ctrl_pkg::PhaseRma));
        check("init_busy in wipe", 32'(init_busy), 32'd0);
      end
    end
    if (wvalid && wready) begin
      ref_mem[{cmd.part, cmd.addr} + (`FLM_ADDR_W + 1)'(wbeat)] = rand_word;
      wbeat++;
      n_wr++;
      n_xfer++;
    end
    if (cmd.start && done) begin
      wbeat = 0;
      if (cmd.op == flash_lcmgr_flash_pkg::FlashOpErase) begin
        n_erase++;
        if (cmd.part == flash_lcmgr_flash_pkg::FlashPartData) begin
          erase_cnt[cmd.addr[`FLM_ADDR_W-1:`FLM_WORD_W]]++;
        end
        for (int w = 0; w < `FLM_WORDS_PER_PAGE; w++) begin
          ref_mem[{cmd.part, cmd.addr[`FLM_ADDR_W-1:`FLM_WORD_W], 4'(w)}] = '1;
        end
      end
      if (cmd.op == flash_lcmgr_flash_pkg::FlashOpRead &&
          cmd.part == flash_lcmgr_flash_pkg::FlashPartInfo) n_info_rd++;
    end
  end

  // about one stall in four, new random word after each transfer
  always @(negedge clk) begin
    stall = (take_bits(2) == 32'd3);
    if (n_rand != n_xfer) begin
      rand_word = take_bits(32);
      n_rand    = n_xfer;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    longint seed_cyc, wipe_cyc;
    seed_cyc = `FLM_NUM_SEEDS * 2 * (`FLM_SEED_WORDS + 2) + 20;
    wipe_cyc = `FLM_WIPE_NUM_PAGES * (2 + (`FLM_WORDS_PER_PAGE / `FLM_PROG_BURST) *
               (2 * `FLM_PROG_BURST + 4)) + 20;
    #(4 * (4 * seed_cyc + 3 * wipe_cyc) * 4);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog");
  end

  initial begin
    lfsr = 32'h4ea86ca9;
    rst_n = 1'b0;
    init = 1'b0;
    prov_en = 1'b0;
    rma_req = 1'b0;
    stall = 1'b0;
    inj_err = 1'b0;
    inj_flip = 1'b0;
    load_en = 1'b0;
    load_idx = '0;
    load_data = '0;
    rand_word = take_bits(32);

    // seed read, validate pass keeps each word
    reset_dut(1'b0, 1'b0);
    prov_en = 1'b1;
    init = 1'b1;
    wait_for(0, "initialized after seed read");
    for (int s = 0; s < `FLM_NUM_SEEDS; s++) begin
      for (int w = 0; w < `FLM_SEED_WORDS; w++) begin
        check("seed word", seeds[(s * `FLM_SEED_WORDS + w) * 32 +: 32],
              ref_mem[{1'b1, 6'(s == 0 ? `FLM_SEED0_PAGE : `FLM_SEED1_PAGE), 4'(w)}]);
      end
    end
    check("seed_err", 32'(seed_err), 32'd0);
    check("init_busy after init", 32'(init_busy), 32'd0);
    check("phase after init", 32'(phase), 32'(flash_lcmgr_ctrl_pkg::PhaseNone));

    // no provisioning
    reset_dut(1'b0, 1'b0);
    init = 1'b1;
    wait_for(0, "initialized without provisioning");
    check("commands issued", 32'(n_start), 32'd0);
    for (int i = 0; i < `FLM_NUM_SEEDS * `FLM_SEED_WORDS; i++) begin
      check("reset seed word", seeds[i * 32 +: 32], `FLM_SEED_RESET);
    end

    // flash error on a seed read
    reset_dut(1'b1, 1'b0);
    prov_en = 1'b1;
    init = 1'b1;
    wait_for(0, "initialized after seed error");
    check("seed_err", 32'(seed_err), 32'd1);

    // rma after init
    reset_dut(1'b0, 1'b0);
    prov_en = 1'b1;
    init = 1'b1;
    wait_for(0, "initialized before rma");
    rma_req = 1'b1;
    wait_for(1, "rma ack after init");
    check_wipe();

    // rma from idle
    reset_dut(1'b0, 1'b0);
    rma_req = 1'b1;
    wait_for(1, "rma ack from idle");
    check("info reads", 32'(n_info_rd), 32'd0);
    check_wipe();

    // corrupted read-back
    reset_dut(1'b0, 1'b1);
    rma_req = 1'b1;
    wait_for(2, "fatal error after bad read-back");
    check("rma_ack", 32'(rma_ack), 32'd0);
    check("dis_access", 32'(dis_access), 32'd1);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: tests/flash_model.sv
/*
 * Behavioral flash behind the arbiter
 * - data and info memory, read, program and page erase
 * - random stalls from the stall input
 * - one-shot error on an info read and bit flip on a data read
 */
`timescale 1ns/1ps
`include "flash_lcmgr_consts.svh"

module flash_model (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  flash_lcmgr_flash_pkg::flash_cmd_t  cmd_i,
  input  logic                               wvalid_i,
  input  flash_lcmgr_flash_pkg::bus_word_t   wdata_i,
  input  logic                               stall_i,
  input  logic                               inj_err_i,
  input  logic                               inj_flip_i,
  input  logic                               load_en_i,
  input  logic [`FLM_ADDR_W:0]               load_idx_i,
  input  flash_lcmgr_flash_pkg::bus_word_t   load_data_i,
  output logic                               done_o,
  output logic                               err_o,
  output logic                               rvalid_o,
  output logic                               wready_o,
  output flash_lcmgr_flash_pkg::bus_word_t   rdata_o
);

  localparam int unsigned MemWords = 2 ** (`FLM_ADDR_W + 1);

  flash_lcmgr_flash_pkg::bus_word_t  mem [MemWords];
  flash_lcmgr_flash_pkg::flash_cmd_t cur;
  flash_lcmgr_flash_pkg::bus_word_t  wr_data;
  flash_lcmgr_flash_pkg::bus_word_t  ld_data;

  logic                  busy;
  logic                  err_used;
  logic                  flip_used;
  logic                  wr_pend;
  logic                  ld_pend;
  logic                  stall_q;
  logic [`FLM_WORD_W:0]  beat;
  logic [`FLM_WORD_W:0]  wcnt;
  logic [`FLM_ADDR_W:0]  wr_idx;
  logic [`FLM_ADDR_W:0]  ld_idx;
  logic [`FLM_ADDR_W:0]  base;

  assign base = {cur.part, cur.addr};

  // fill depends on every address bit
  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = 32'h5a3c0000 ^ (32'(i) * 32'h00010003);
    end
  end

  // write beats, preload words and stalls are taken at the rising edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pend <= 1'b0;
      wcnt    <= '0;
      ld_pend <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      wr_pend <= busy && wvalid_i && wready_o;
      wr_data <= wdata_i;
      wr_idx  <= base + (`FLM_ADDR_W + 1)'(wcnt);
      ld_pend <= load_en_i;
      ld_idx  <= load_idx_i;
      ld_data <= load_data_i;
      stall_q <= stall_i;
      if (done_o) begin
        wcnt <= '0;
      end else if (busy && wvalid_i && wready_o) begin
        wcnt <= wcnt + 1'b1;
      end
    end
  end

  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy      <= 1'b0;
      beat      <= '0;
      cur       <= '0;
      done_o    <= 1'b0;
      err_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      wready_o  <= 1'b0;
      rdata_o   <= '0;
      err_used  <= 1'b0;
      flip_used <= 1'b0;
    end else begin
      done_o   <= 1'b0;
      err_o    <= 1'b0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (ld_pend) begin
        mem[ld_idx] <= ld_data;
      end
      if (wr_pend) begin
        mem[wr_idx] <= wr_data;
      end
      if (!busy) begin
        if (cmd_i.start) begin
          cur  <= cmd_i;
          busy <= 1'b1;
          beat <= '0;
        end
      end else if (!stall_q) begin
        case (cur.op)
          flash_lcmgr_flash_pkg::FlashOpRead: begin
            if (beat <= {1'b0, cur.num}) begin
              rdata_o  <= mem[base + (`FLM_ADDR_W + 1)'(beat)];
              rvalid_o <= 1'b1;
              beat     <= beat + 1'b1;
              if (inj_flip_i && !flip_used && cur.part == flash_lcmgr_flash_pkg::FlashPartData) begin
                rdata_o   <= mem[base + (`FLM_ADDR_W + 1)'(beat)] ^ 32'h1;
                flip_used <= 1'b1;
              end
            end else begin
              done_o <= 1'b1;
              busy   <= 1'b0;
              if (inj_err_i && !err_used && cur.part == flash_lcmgr_flash_pkg::FlashPartInfo) begin
                err_o    <= 1'b1;
                err_used <= 1'b1;
              end
            end
          end
          flash_lcmgr_flash_pkg::FlashOpProgram: begin
            if (wcnt <= {1'b0, cur.num}) begin
              wready_o <= 1'b1;
            end else begin
              done_o <= 1'b1;
              busy   <= 1'b0;
            end
          end
          default: begin
            // page erase
            for (int w = 0; w < `FLM_WORDS_PER_PAGE; w++) begin
              mem[{cur.part, cur.addr[`FLM_ADDR_W-1:`FLM_WORD_W], 4'(w)}] <= '1;
            end
            done_o <= 1'b1;
            busy   <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

// File: tests/tb_clkgen.sv
/*
 * Testbench clock source, 4 ns period
 */
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: hdl/flash_lcmgr_top.sv
/*
 * Flash life-cycle manager top
 * - init synchronizer and phase state machine
 * - seed reader and RMA wiper instances
 * - command multiplexer towards the arbiter
 */
`timescale 1ns/1ps
`include "flash_lcmgr_consts.svh"

module flash_lcmgr_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                init_i,
  input  logic                                provision_en_i,
  input  logic                                rma_req_i,
  input  logic                                done_i,
  input  logic                                err_i,
  input  logic                                rvalid_i,
  input  flash_lcmgr_flash_pkg::bus_word_t    rdata_i,
  input  logic                                wready_i,
  input  flash_lcmgr_flash_pkg::bus_word_t    rand_i,
  output flash_lcmgr_flash_pkg::flash_cmd_t   cmd_o,
  output logic                                wvalid_o,
  output flash_lcmgr_flash_pkg::bus_word_t    wdata_o,
  output flash_lcmgr_ctrl_pkg::seeds_t        seeds_o,
  output logic                                seed_err_o,
  output logic                                rma_ack_o,
  output logic                                dis_access_o,
  output logic                                init_busy_o,
  output logic                                initialized_o,
  output logic                                fatal_err_o,
  output flash_lcmgr_ctrl_pkg::lcmgr_phase_e  phase_o
);

  flash_lcmgr_ctrl_pkg::lcmgr_state_e state_q, state_d;
  flash_lcmgr_ctrl_pkg::lcmgr_phase_e phase;
  flash_lcmgr_flash_pkg::flash_cmd_t  seed_cmd, wipe_cmd;

  logic init_meta_q, init_sync_q;
  logic seed_req, seed_done;
  logic wipe_req, wipe_done, wipe_err;

  // init comes from another domain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_meta_q <= 1'b0;
      init_sync_q <= 1'b0;
      state_q     <= flash_lcmgr_ctrl_pkg::StIdle;
    end else begin
      init_meta_q <= init_i;
      init_sync_q <= init_meta_q;
      state_q     <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // phase state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      flash_lcmgr_ctrl_pkg::StIdle: begin
        // rma wins over init
        if (rma_req_i) begin
          state_d = flash_lcmgr_ctrl_pkg::StWipe;
        end else if (init_sync_q) begin
          state_d = provision_en_i ? flash_lcmgr_ctrl_pkg::StSeed : flash_lcmgr_ctrl_pkg::StWait;
        end
      end
      flash_lcmgr_ctrl_pkg::StSeed: begin
        if (seed_done) state_d = flash_lcmgr_ctrl_pkg::StWait;
      end
      flash_lcmgr_ctrl_pkg::StWait: begin
        if (rma_req_i) state_d = flash_lcmgr_ctrl_pkg::StWipe;
      end
      flash_lcmgr_ctrl_pkg::StWipe: begin
        if (wipe_done) begin
          state_d = wipe_err ? flash_lcmgr_ctrl_pkg::StInvalid : flash_lcmgr_ctrl_pkg::StRmaRsp;
        end
      end
      flash_lcmgr_ctrl_pkg::StRmaRsp, flash_lcmgr_ctrl_pkg::StInvalid: begin
        state_d = state_q;
      end
      default: state_d = flash_lcmgr_ctrl_pkg::StInvalid;
    endcase
  end

  always_comb begin
    unique case (state_q)
      flash_lcmgr_ctrl_pkg::StSeed:   phase = flash_lcmgr_ctrl_pkg::PhaseSeed;
      flash_lcmgr_ctrl_pkg::StWipe,
      flash_lcmgr_ctrl_pkg::StRmaRsp: phase = flash_lcmgr_ctrl_pkg::PhaseRma;
      default:                        phase = flash_lcmgr_ctrl_pkg::PhaseNone;
    endcase
  end

  assign seed_req = (state_q == flash_lcmgr_ctrl_pkg::StSeed);
  assign wipe_req = (state_q == flash_lcmgr_ctrl_pkg::StWipe);

  flash_lcmgr_seed_rd u_seed_rd (
    .clk_i, .rst_ni,
    .seed_req_i(seed_req), .done_i, .err_i, .rvalid_i, .rdata_i,
    .cmd_o(seed_cmd), .seed_done_o(seed_done), .seeds_o, .seed_err_o
  );

  flash_lcmgr_rma_wipe u_rma_wipe (
    .clk_i, .rst_ni,
    .wipe_req_i(wipe_req), .done_i, .err_i, .rvalid_i, .rdata_i, .wready_i, .rand_i,
    .cmd_o(wipe_cmd), .wvalid_o, .wipe_done_o(wipe_done), .wipe_err_o(wipe_err)
  );

  // one sequencer owns the arbiter at a time
  assign cmd_o   = (phase == flash_lcmgr_ctrl_pkg::PhaseSeed) ? seed_cmd : wipe_cmd;
  assign wdata_o = rand_i;
  assign phase_o = phase;

  assign init_busy_o   = seed_req;
  assign initialized_o = (state_q == flash_lcmgr_ctrl_pkg::StWait);
  assign rma_ack_o     = rma_req_i & (state_q == flash_lcmgr_ctrl_pkg::StRmaRsp);
  assign fatal_err_o   = (state_q == flash_lcmgr_ctrl_pkg::StInvalid);
  assign dis_access_o  = fatal_err_o | (state_q == flash_lcmgr_ctrl_pkg::StRmaRsp);

endmodule

// File: hdl/flash_lcmgr_rma_wipe.sv
/*
 * RMA page wipe sequencer
 * - page erase over the fixed data page range
 * - burst program with random data, latched per beat
 * - read back and compare, sticky wipe error
 */
`timescale 1ns/1ps
`include "flash_lcmgr_consts.svh"

module flash_lcmgr_rma_wipe (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                wipe_req_i,
  input  logic                                done_i,
  input  logic                                err_i,
  input  logic                                rvalid_i,
  input  flash_lcmgr_flash_pkg::bus_word_t    rdata_i,
  input  logic                                wready_i,
  input  flash_lcmgr_flash_pkg::bus_word_t    rand_i,
  output flash_lcmgr_flash_pkg::flash_cmd_t   cmd_o,
  output logic                                wvalid_o,
  output logic                                wipe_done_o,
  output logic                                wipe_err_o
);

  localparam int unsigned WordW    = `FLM_WORD_W;
  localparam int unsigned PageW    = `FLM_ADDR_W - `FLM_WORD_W;
  localparam int unsigned BeatW    = $clog2(`FLM_PROG_BURST);
  localparam int unsigned EndPage  = `FLM_WIPE_START_PAGE + `FLM_WIPE_NUM_PAGES;
  localparam int unsigned LastBeat = `FLM_PROG_BURST - 1;

  flash_lcmgr_ctrl_pkg::wipe_state_e state_q, state_d;

  logic [PageW-1:0] page_cnt_q;
  logic [WordW:0]   word_cnt_q;
  logic [BeatW-1:0] beat_cnt_q;
  logic             err_q;

  logic page_ld;
  logic page_incr;
  logic word_clr;
  logic word_incr;
  logic beat_clr;
  logic err_set;
  logic wr_beat;
  logic rd_beat;
  logic mismatch;

  flash_lcmgr_flash_pkg::bus_word_t [`FLM_PROG_BURST-1:0] prog_data_q;

  assign wvalid_o = (state_q == flash_lcmgr_ctrl_pkg::WpProgram);
  assign wr_beat  = wvalid_o & wready_i;
  assign rd_beat  = (state_q == flash_lcmgr_ctrl_pkg::WpVerify) & rvalid_i;
  assign mismatch = rd_beat & (rdata_i != prog_data_q[beat_cnt_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= flash_lcmgr_ctrl_pkg::WpIdle;
      page_cnt_q <= '0;
      word_cnt_q <= '0;
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (page_ld) begin
        page_cnt_q <= PageW'(`FLM_WIPE_START_PAGE);
      end else if (page_incr) begin
        page_cnt_q <= page_cnt_q + 1'b1;
      end
      if (word_clr) begin
        word_cnt_q <= '0;
      end else if (word_incr) begin
        word_cnt_q <= word_cnt_q + (WordW+1)'(`FLM_PROG_BURST);
      end
      if (beat_clr) begin
        beat_cnt_q <= '0;
      end else if (wr_beat || rd_beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      // once set, only a reset clears it
      if (err_set) begin
        err_q <= 1'b1;
      end
    end
  end

  // random words as they go out, compared on read back
  always_ff @(posedge clk_i) begin
    if (wr_beat) begin
      prog_data_q[beat_cnt_q] <= rand_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // wipe state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cmd_o.start = 1'b0;
    cmd_o.op    = flash_lcmgr_flash_pkg::FlashOpRead;
    cmd_o.num   = WordW'(LastBeat);
    wipe_done_o = 1'b0;
    page_ld     = 1'b0;
    page_incr   = 1'b0;
    word_clr    = 1'b0;
    word_incr   = 1'b0;
    beat_clr    = 1'b0;
    err_set     = 1'b0;

    unique case (state_q)
      flash_lcmgr_ctrl_pkg::WpIdle: begin
        if (wipe_req_i) begin
          page_ld  = 1'b1;
          word_clr = 1'b1;
          state_d  = flash_lcmgr_ctrl_pkg::WpPageSel;
        end
      end

      flash_lcmgr_ctrl_pkg::WpPageSel: begin
        if (page_cnt_q < PageW'(EndPage)) begin
          state_d = flash_lcmgr_ctrl_pkg::WpErase;
        end else begin
          wipe_done_o = 1'b1;
          state_d     = flash_lcmgr_ctrl_pkg::WpIdle;
        end
      end

      flash_lcmgr_ctrl_pkg::WpErase: begin
        cmd_o.start = 1'b1;
        cmd_o.op    = flash_lcmgr_flash_pkg::FlashOpErase;
        cmd_o.num   = '0;
        if (done_i) begin
          err_set = err_i;
          state_d = flash_lcmgr_ctrl_pkg::WpWordSel;
        end
      end

      flash_lcmgr_ctrl_pkg::WpWordSel: begin
        if (word_cnt_q < (WordW+1)'(`FLM_WORDS_PER_PAGE)) begin
          state_d = flash_lcmgr_ctrl_pkg::WpProgram;
        end else begin
          page_incr = 1'b1;
          word_clr  = 1'b1;
          state_d   = flash_lcmgr_ctrl_pkg::WpPageSel;
        end
      end

      flash_lcmgr_ctrl_pkg::WpProgram: begin
        cmd_o.start = 1'b1;
        cmd_o.op    = flash_lcmgr_flash_pkg::FlashOpProgram;
        if (wr_beat && beat_cnt_q == BeatW'(LastBeat)) begin
          beat_clr = 1'b1;
          state_d  = flash_lcmgr_ctrl_pkg::WpProgWait;
        end
      end

      flash_lcmgr_ctrl_pkg::WpProgWait: begin
        cmd_o.start = 1'b1;
        cmd_o.op    = flash_lcmgr_flash_pkg::FlashOpProgram;
        if (done_i) begin
          err_set = err_i;
          state_d = flash_lcmgr_ctrl_pkg::WpVerify;
        end
      end

      flash_lcmgr_ctrl_pkg::WpVerify: begin
        cmd_o.start = 1'b1;
        err_set     = mismatch | (done_i & err_i);
        if (done_i) begin
          beat_clr  = 1'b1;
          word_incr = 1'b1;
          state_d   = flash_lcmgr_ctrl_pkg::WpWordSel;
        end
      end

      flash_lcmgr_ctrl_pkg::WpInvalid: begin
        err_set = 1'b1;
      end

      default: begin
        state_d = flash_lcmgr_ctrl_pkg::WpInvalid;
      end
    endcase
  end

  assign cmd_o.part = flash_lcmgr_flash_pkg::FlashPartData;
  assign cmd_o.addr = {page_cnt_q, word_cnt_q[WordW-1:0]};
  assign wipe_err_o = err_q;

endmodule

// File: hdl/flash_lcmgr_seed_rd.sv
/*
 * Seed read sequencer
 * - two info partition reads per seed, store then validate
 * - seed storage with the reset pattern
 * - sticky seed error
 */
`timescale 1ns/1ps
`include "flash_lcmgr_consts.svh"

module flash_lcmgr_seed_rd (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                seed_req_i,
  input  logic                                done_i,
  input  logic                                err_i,
  input  logic                                rvalid_i,
  input  flash_lcmgr_flash_pkg::bus_word_t    rdata_i,
  output flash_lcmgr_flash_pkg::flash_cmd_t   cmd_o,
  output logic                                seed_done_o,
  output flash_lcmgr_ctrl_pkg::seeds_t        seeds_o,
  output logic                                seed_err_o
);

  localparam int unsigned SeedIdxW = $clog2(`FLM_NUM_SEEDS);
  localparam int unsigned BeatW    = $clog2(`FLM_SEED_WORDS);
  localparam int unsigned WordW    = `FLM_WORD_W;
  localparam int unsigned PageW    = `FLM_ADDR_W - `FLM_WORD_W;
  localparam int unsigned NumWords = `FLM_NUM_SEEDS * `FLM_SEED_WORDS;

  localparam flash_lcmgr_ctrl_pkg::seed_t SeedRst = {`FLM_SEED_WORDS{`FLM_SEED_RESET}};

  logic [SeedIdxW-1:0]       seed_cnt_q;
  logic [BeatW-1:0]          beat_cnt_q;
  logic                      validate_q;
  logic                      seed_err_q;
  logic                      cmd_done;
  logic                      last_seed;
  logic [PageW-1:0]          seed_page;
  logic [SeedIdxW+BeatW-1:0] word_idx;

  flash_lcmgr_flash_pkg::bus_word_t [NumWords-1:0] seeds_q;

  // the read runs for as long as the top holds the request
  assign cmd_done    = seed_req_i & done_i;
  assign last_seed   = (seed_cnt_q == SeedIdxW'(`FLM_NUM_SEEDS - 1));
  assign seed_done_o = cmd_done & validate_q & last_seed;

  assign seed_page = (seed_cnt_q == '0) ? PageW'(`FLM_SEED0_PAGE) : PageW'(`FLM_SEED1_PAGE);
  assign word_idx  = {seed_cnt_q, beat_cnt_q};

  ////////////////////////////////////////////////////////////////////////////
  // seed, pass and beat counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seed_cnt_q <= '0;
      beat_cnt_q <= '0;
      validate_q <= 1'b0;
      seed_err_q <= 1'b0;
    end else begin
      if (cmd_done) begin
        beat_cnt_q <= '0;
        if (validate_q) begin
          // second pass finished, next seed or wrap for the next init
          validate_q <= 1'b0;
          seed_cnt_q <= last_seed ? '0 : seed_cnt_q + 1'b1;
        end else begin
          validate_q <= 1'b1;
        end
      end else if (seed_req_i && rvalid_i) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (cmd_done && err_i) begin
        seed_err_q <= 1'b1;
      end
    end
  end

  // first pass stores, validate pass ands into the stored word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seeds_q <= {`FLM_NUM_SEEDS{SeedRst}};
    end else if (seed_req_i && rvalid_i) begin
      if (validate_q) begin
        seeds_q[word_idx] <= seeds_q[word_idx] & rdata_i;
      end else begin
        seeds_q[word_idx] <= rdata_i;
      end
    end
  end

  always_comb begin
    cmd_o.start = seed_req_i;
    cmd_o.op    = flash_lcmgr_flash_pkg::FlashOpRead;
    cmd_o.part  = flash_lcmgr_flash_pkg::FlashPartInfo;
    cmd_o.addr  = {seed_page, {WordW{1'b0}}};
    cmd_o.num   = WordW'(`FLM_SEED_WORDS - 1);
  end

  assign seeds_o    = seeds_q;
  assign seed_err_o = seed_err_q;

endmodule

// File: hdl/flash_lcmgr_ctrl_pkg.sv
/*
 * Life-cycle manager control types
 * - hardware interface phase
 * - top and wipe state machine encodings
 * - seed storage vectors
 */
`include "flash_lcmgr_consts.svh"

package flash_lcmgr_ctrl_pkg;

  typedef enum logic [1:0] {
    PhaseNone = 2'd0,
    PhaseSeed = 2'd1,
    PhaseRma  = 2'd2
  } lcmgr_phase_e;

  // top level sequencing
  typedef enum logic [2:0] {
    StIdle,
    StSeed,
    StWait,
    StWipe,
    StRmaRsp,
    StInvalid
  } lcmgr_state_e;

  // page wipe sequencing
  typedef enum logic [2:0] {
    WpIdle,
    WpPageSel,
    WpErase,
    WpWordSel,
    WpProgram,
    WpProgWait,
    WpVerify,
    WpInvalid
  } wipe_state_e;

  typedef logic [`FLM_SEED_WORDS*`FLM_BUS_W-1:0] seed_t;
  typedef logic [`FLM_NUM_SEEDS*`FLM_SEED_WORDS*`FLM_BUS_W-1:0] seeds_t;

endpackage

// File: hdl/flash_lcmgr_flash_pkg.sv
/*
 * Flash command interface types
 * - data word and word address vectors
 * - operation and partition encodings
 * - command struct driven towards the arbiter
 */
`include "flash_lcmgr_consts.svh"

package flash_lcmgr_flash_pkg;

  // one flash data word
  typedef logic [`FLM_BUS_W-1:0] bus_word_t;

  // word address, page in the upper bits and word in page below
  typedef logic [`FLM_ADDR_W-1:0] word_addr_t;

  typedef enum logic [1:0] {
    FlashOpRead    = 2'd0,
    FlashOpProgram = 2'd1,
    FlashOpErase   = 2'd2
  } flash_op_e;

  typedef enum logic {
    FlashPartData = 1'b0,
    FlashPartInfo = 1'b1
  } flash_part_e;

  ////////////////////////////////////////////////////////////////////////////
  // command to the arbiter
  ////////////////////////////////////////////////////////////////////////////

  // num is the number of words minus one
  typedef struct packed {
    logic                    start;
    flash_op_e               op;
    flash_part_e             part;
    word_addr_t              addr;
    logic [`FLM_WORD_W-1:0]  num;
  } flash_cmd_t;

endpackage

// File: include/flash_lcmgr_consts.svh
/*
 * Flash life-cycle manager constants
 * - flash word, address and page geometry
 * - seed count, size and info page locations
 * - RMA wipe page range and program burst size
 */
`ifndef FLASH_LCMGR_CONSTS_SVH
`define FLASH_LCMGR_CONSTS_SVH

// flash geometry
`define FLM_BUS_W           32
`define FLM_ADDR_W          10
`define FLM_WORD_W          4
`define FLM_WORDS_PER_PAGE  16

// seeds in the info partition
`define FLM_NUM_SEEDS       2
`define FLM_SEED_WORDS      4
`define FLM_SEED0_PAGE      1
`define FLM_SEED1_PAGE      2

// rma wipe range, data partition
`define FLM_WIPE_START_PAGE 8
`define FLM_WIPE_NUM_PAGES  4
`define FLM_PROG_BURST      4

// value of every seed word out of reset
`define FLM_SEED_RESET      32'hdeadbeef

`endif
